// File: src.f
src/pkt_check_pkg.sv
src/axis_word_if.sv
src/pkt_summary_if.sv
src/axis_rx_stage.sv
src/pkt_reassembler.sv
src/expected_table_matcher.sv
src/axis_packet_checker_top.sv
bench/axis_packet_checker_assertions.sv
bench/tb_axis_packet_checker.sv

// File: run_sim.sh
#!/bin/sh
# Builds the packet checker testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axis_packet_checker \
    -f src.f \
    -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: bench/packets_golden.txt
// One record per line, hex: 1 index dest length crc = table load, 2 dest data keep last = beat
// 3 index = expect match, 4 = expect miss, 5 count all = check received_count and all_received, 0 = end
// Table, entry 1 differs from entry 2 only in length and entry 7 stays unloaded
1 0 0 009 cbf43926
1 1 0 004 352441c2
1 2 0 003 352441c2
1 3 1 00e 20159d7f
1 4 2 01a 4c2750bd
1 5 3 00b 0d4a1185
1 6 0 001 e8b7be43
// "123456789" on dest 0, last beat keeps one byte
2 0 34333231 f 0
2 0 38373635 f 0
2 0 5a5a5a39 1 1
3 0
// "abc" in one partial beat, the length 4 entry is skipped
2 0 ee636261 7 1
3 2
5 2 0
// "message digest" on dest 1 interleaved with the alphabet on dest 2
2 1 7373656d f 0
2 2 64636261 f 0
2 1 20656761 f 0
2 2 68676665 f 0
2 1 65676964 f 0
2 2 6c6b6a69 f 0
2 1 00007473 3 1
3 3
2 2 706f6e6d f 0
2 2 74737271 f 0
2 2 78777675 f 0
2 2 00007a79 3 1
3 4
// "hello world" on dest 3 with the second o turned into O
2 3 6c6c6568 f 0
2 3 4f77206f f 0
2 3 00646c72 7 1
4
5 4 0
// Same packet intact
2 3 6c6c6568 f 0
2 3 6f77206f f 0
2 3 00646c72 7 1
3 5
// "a" twice, the copy finds entry 6 claimed
2 0 00000061 1 1
3 6
2 0 00000061 1 1
4
5 6 0
// Reload of entry 6 clears its claim
1 6 0 001 e8b7be43
2 0 00000061 1 1
3 6
// Entry 1 becomes four 0xff bytes, whose CRC-32 is all ones
1 1 0 004 ffffffff
2 0 ffffffff f 1
3 1
5 8 1
0

// File: bench/tb_axis_packet_checker.sv
// Run from the project root so that bench/packets_golden.txt is found
// Results are expected in the order of the packets' last beats
`timescale 1ns/10ps
`default_nettype none

module tb_axis_packet_checker;
    import pkt_check_pkg::*;

    localparam int NUM_EXPECTED = 8;
    localparam int IDX_W        = $clog2(NUM_EXPECTED);
    localparam int GOLDEN_WORDS = 512;

    logic             axis_packet_in;
    logic             rst_n;
    logic             tvalid;
    logic             tready;
    data_t            tdata;
    keep_t            tkeep;
    logic             tlast;
    dest_t            tdest;
    logic             exp_wr;
    logic [IDX_W-1:0] exp_index;
    dest_t            exp_dest;
    blen_t            exp_blen;
    crc_t             exp_crc;
    logic             match;
    logic             miss;
    logic [IDX_W-1:0] match_index;
    logic [IDX_W:0]   received_count;
    logic             all_received;

    logic [31:0] golden [GOLDEN_WORDS];
    // Match index, or -1 for a miss
    int          expected_outcome [$];
    int          next_outcome;
    int          outcomes_pushed = 0;
    int          outcomes_seen   = 0;
    int          cycle_count     = 0;
    int          cycle_limit     = 1000;
    integer      seed;

    axis_packet_checker_top #(
        .NUM_EXPECTED (NUM_EXPECTED)
    ) axis_packet_checker_top_inst (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .tvalid         (tvalid),
        .tready         (tready),
        .tdata          (tdata),
        .tkeep          (tkeep),
        .tlast          (tlast),
        .tdest          (tdest),
        .exp_wr         (exp_wr),
        .exp_index      (exp_index),
        .exp_dest       (exp_dest),
        .exp_blen       (exp_blen),
        .exp_crc        (exp_crc),
        .match          (match),
        .miss           (miss),
        .match_index    (match_index),
        .received_count (received_count),
        .all_received   (all_received)
    );

    bind axis_packet_checker_top axis_packet_checker_assertions #(
        .NUM_EXPECTED (NUM_EXPECTED)
    ) axis_packet_checker_assertions_inst (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .tvalid         (tvalid),
        .tready         (tready),
        .tdata          (tdata),
        .tkeep          (tkeep),
        .tlast          (tlast),
        .tdest          (tdest),
        .match          (match),
        .miss           (miss),
        .received_count (received_count)
    );

    always #10 axis_packet_in = ~axis_packet_in;

    ////////////////////////////////////////
    // Failure handling

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input logic [63:0] observed, input logic [63:0] expected,
                               input string what);
        if (observed !== expected) begin
            $display("[FAIL] %0d ns: %s is %0h, expected %0h", $time, what, observed, expected);
            abort_run();
        end
    endtask

    always @(posedge axis_packet_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    // Result pulses are stable at the falling edge
    always @(negedge axis_packet_in) begin
        if (rst_n && (match || miss)) begin
            if (expected_outcome.size() == 0) begin
                $display("Result pulse at %0d ns with no packet outstanding", $time);
                abort_run();
            end else begin
                next_outcome = expected_outcome.pop_front();
                if (next_outcome < 0) begin
                    check_value(64'({match, miss}), 64'(2'b01), "match/miss for a miss");
                end else begin
                    check_value(64'({match, miss}), 64'(2'b10), "match/miss for a match");
                    check_value(64'(match_index), 64'(next_outcome), "match_index");
                end
                outcomes_seen++;
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus

    function automatic int count_beats();
        int p;
        int beats;
        p     = 0;
        beats = 0;
        while (p < GOLDEN_WORDS && golden[p] != 32'd0) begin
            case (golden[p])
                32'd1: p += 5;
                32'd2: begin
                    beats++;
                    p += 5;
                end
                32'd3: p += 2;
                32'd4: p += 1;
                32'd5: p += 3;
                default: p = GOLDEN_WORDS;
            endcase
        end
        return beats;
    endfunction

    task automatic wait_for_outcomes();
        while (outcomes_seen < outcomes_pushed) begin
            @(posedge axis_packet_in);
            #1;
        end
    endtask

    task automatic load_entry(input logic [IDX_W-1:0] index, input dest_t dest,
                              input blen_t blen, input crc_t crc);
        exp_wr    = 1'b1;
        exp_index = index;
        exp_dest  = dest;
        exp_blen  = blen;
        exp_crc   = crc;
        @(posedge axis_packet_in);
        #1;
        exp_wr = 1'b0;
    endtask

    task automatic send_beat(input dest_t dest, input data_t data, input keep_t keep,
                             input logic last);
        logic [31:0] draw;
        int          gap;
        bit          taken;
        draw = $random(seed);
        gap  = draw[2] ? int'(draw[1:0]) : 0;
        repeat (gap) begin
            @(posedge axis_packet_in);
            #1;
        end
        tvalid = 1'b1;
        tdest  = dest;
        tdata  = data;
        tkeep  = keep;
        tlast  = last;
        taken  = 1'b0;
        // tready seen at the falling edge holds through the next rising edge
        while (!taken) begin
            @(negedge axis_packet_in);
            taken = tready;
            @(posedge axis_packet_in);
            #1;
        end
        tvalid = 1'b0;
    endtask

    task automatic run_golden();
        int p;
        bit done;
        p    = 0;
        done = 1'b0;
        while (!done) begin
            case (golden[p])
                32'd1: begin
                    wait_for_outcomes();
                    load_entry(IDX_W'(golden[p+1]), dest_t'(golden[p+2]),
                               blen_t'(golden[p+3]), golden[p+4]);
                    p += 5;
                end
                32'd2: begin
                    send_beat(dest_t'(golden[p+1]), golden[p+2], keep_t'(golden[p+3]),
                              golden[p+4][0]);
                    p += 5;
                end
                32'd3: begin
                    expected_outcome.push_back(int'(golden[p+1]));
                    outcomes_pushed++;
                    p += 2;
                end
                32'd4: begin
                    expected_outcome.push_back(-1);
                    outcomes_pushed++;
                    p += 1;
                end
                32'd5: begin
                    wait_for_outcomes();
                    check_value(64'(received_count), 64'(golden[p+1]), "received_count");
                    check_value(64'(all_received), 64'(golden[p+2]), "all_received");
                    p += 3;
                end
                32'd0: done = 1'b1;
                default: begin
                    $display("Unknown record type %0h at word %0d of the golden file",
                             golden[p], p);
                    abort_run();
                end
            endcase
        end
    endtask

    initial begin
        seed           = 32'h4fce866f;
        axis_packet_in = 1'b0;
        rst_n          = 1'b1;
        tvalid         = 1'b0;
        tdata          = '0;
        tkeep          = '0;
        tlast          = 1'b0;
        tdest          = '0;
        exp_wr         = 1'b0;
        exp_index      = '0;
        exp_dest       = '0;
        exp_blen       = '0;
        exp_crc        = '0;
        for (int i = 0; i < GOLDEN_WORDS; i++) begin
            golden[i] = '0;
        end
        $readmemh("bench/packets_golden.txt", golden);
        if (count_beats() == 0) begin
            $display("No beats found in bench/packets_golden.txt");
            abort_run();
        end
        cycle_limit = count_beats() * (NUM_EXPECTED + 4) + 200;

        #2 rst_n = 1'b0;
        repeat (3) @(posedge axis_packet_in);
        #1 rst_n = 1'b1;
        @(posedge axis_packet_in);
        #1;

        run_golden();
        wait_for_outcomes();
        // Quiet tail so a stray pulse is still caught
        repeat (NUM_EXPECTED + 4) @(posedge axis_packet_in);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/axis_packet_checker_assertions.sv
// Protocol checks on the top-level ports of the packet checker
// Meant to be bound into axis_packet_checker_top with the same NUM_EXPECTED
`timescale 1ns/10ps
`default_nettype none

module axis_packet_checker_assertions #(
    parameter int NUM_EXPECTED = 8
) (
    input logic                          axis_packet_in,
    input logic                          rst_n,
    input logic                          tvalid,
    input logic                          tready,
    input pkt_check_pkg::data_t          tdata,
    input pkt_check_pkg::keep_t          tkeep,
    input logic                          tlast,
    input pkt_check_pkg::dest_t          tdest,
    input logic                          match,
    input logic                          miss,
    input logic [$clog2(NUM_EXPECTED):0] received_count
);

    // No beat may be taken right out of reset
    tready_low_after_reset: assert property (
        @(posedge axis_packet_in) !rst_n |=> !tready
    ) else $error("tready high in the cycle after reset");

    match_miss_exclusive: assert property (
        @(posedge axis_packet_in) disable iff (!rst_n) !(match && miss)
    ) else $error("match and miss high together");

    count_never_falls: assert property (
        @(posedge axis_packet_in) disable iff (!rst_n)
        received_count >= $past(received_count)
    ) else $error("received_count decreased");

    // A stalled beat stays put until it is taken
    stalled_beat_stable: assert property (
        @(posedge axis_packet_in) disable iff (!rst_n)
        (tvalid && !tready) |=> (tvalid && $stable({tdata, tkeep, tlast, tdest}))
    ) else $error("stalled beat changed before acceptance");

endmodule

`default_nettype wire

// File: src/axis_packet_checker_top.sv
// AXI-Stream packet checker, packets are compared by destination, length and CRC only
`timescale 1ns/10ps
`default_nettype none

module axis_packet_checker_top #(
    parameter int NUM_EXPECTED = 8
) (
    input  logic                            axis_packet_in,
    input  logic                            rst_n,
    // Stream input
    input  logic                            tvalid,
    output logic                            tready,
    input  pkt_check_pkg::data_t            tdata,
    input  pkt_check_pkg::keep_t            tkeep,
    input  logic                            tlast,
    input  pkt_check_pkg::dest_t            tdest,
    // Table load
    input  logic                            exp_wr,
    input  logic [$clog2(NUM_EXPECTED)-1:0] exp_index,
    input  pkt_check_pkg::dest_t            exp_dest,
    input  pkt_check_pkg::blen_t            exp_blen,
    input  pkt_check_pkg::crc_t             exp_crc,
    // Results
    output logic                            match,
    output logic                            miss,
    output logic [$clog2(NUM_EXPECTED)-1:0] match_index,
    output logic [$clog2(NUM_EXPECTED):0]   received_count,
    output logic                            all_received
);

    axis_word_if   word_bus ();
    pkt_summary_if summary_bus ();

    axis_rx_stage axis_rx_stage_inst (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .tvalid         (tvalid),
        .tready         (tready),
        .tdata          (tdata),
        .tkeep          (tkeep),
        .tlast          (tlast),
        .tdest          (tdest),
        .out            (word_bus.src)
    );

    pkt_reassembler pkt_reassembler_inst (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .in             (word_bus.dst),
        .summary        (summary_bus.src)
    );

    expected_table_matcher #(
        .NUM_EXPECTED (NUM_EXPECTED)
    ) expected_table_matcher_inst (
        .axis_packet_in (axis_packet_in),
        .rst_n          (rst_n),
        .exp_wr         (exp_wr),
        .exp_index      (exp_index),
        .exp_dest       (exp_dest),
        .exp_blen       (exp_blen),
        .exp_crc        (exp_crc),
        .summary        (summary_bus.dst),
        .match          (match),
        .miss           (miss),
        .match_index    (match_index),
        .received_count (received_count),
        .all_received   (all_received)
    );

endmodule

`default_nettype wire

// File: src/expected_table_matcher.sv
// Expected-packet table with one entry compared per cycle, NUM_EXPECTED must be at least 2
// A load and a claim on the same entry in one cycle leave the entry loaded and unclaimed
`timescale 1ns/10ps
`default_nettype none

module expected_table_matcher #(
    parameter int NUM_EXPECTED = 8
) (
    input  logic                            axis_packet_in,
    input  logic                            rst_n,
    input  logic                            exp_wr,
    input  logic [$clog2(NUM_EXPECTED)-1:0] exp_index,
    input  pkt_check_pkg::dest_t            exp_dest,
    input  pkt_check_pkg::blen_t            exp_blen,
    input  pkt_check_pkg::crc_t             exp_crc,
    pkt_summary_if.dst                      summary,
    output logic                            match,
    output logic                            miss,
    output logic [$clog2(NUM_EXPECTED)-1:0] match_index,
    output logic [$clog2(NUM_EXPECTED):0]   received_count,
    output logic                            all_received
);
    import pkt_check_pkg::*;

    localparam int IDX_W = $clog2(NUM_EXPECTED);

    typedef enum logic {
        ST_IDLE,
        ST_SEARCH
    } state_t;

    state_t                  state;
    dest_t                   tab_dest  [NUM_EXPECTED];
    blen_t                   tab_blen  [NUM_EXPECTED];
    crc_t                    tab_crc   [NUM_EXPECTED];
    logic [NUM_EXPECTED-1:0] tab_valid;
    logic [NUM_EXPECTED-1:0] tab_claimed;
    dest_t                   key_dest;
    blen_t                   key_blen;
    crc_t                    key_crc;
    logic [IDX_W-1:0]        scan_idx;
    logic                    hit;
    logic                    scan_end;

    assign summary.ready = (state == ST_IDLE);

    // Compare the current entry against the captured summary
    assign hit = (state == ST_SEARCH) && tab_valid[scan_idx] && !tab_claimed[scan_idx]
              && (tab_dest[scan_idx] == key_dest) && (tab_blen[scan_idx] == key_blen)
              && (tab_crc[scan_idx] == key_crc);
    assign scan_end = (scan_idx == IDX_W'(NUM_EXPECTED - 1));

    assign all_received = (|tab_valid) && ((tab_valid & ~tab_claimed) == '0);

    ////////////////////////////////////////
    // Search FSM and flags

    always_ff @(posedge axis_packet_in or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            scan_idx       <= '0;
            match          <= 1'b0;
            miss           <= 1'b0;
            match_index    <= '0;
            received_count <= '0;
            tab_valid      <= '0;
            tab_claimed    <= '0;
        end else begin
            match <= 1'b0;
            miss  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (summary.valid) begin
                        state    <= ST_SEARCH;
                        scan_idx <= '0;
                    end
                end
                ST_SEARCH: begin
                    if (hit) begin
                        match                 <= 1'b1;
                        match_index           <= scan_idx;
                        tab_claimed[scan_idx] <= 1'b1;
                        // Saturate so the count never falls
                        if (received_count != '1) begin
                            received_count <= received_count + 1'b1;
                        end
                        state <= ST_IDLE;
                    end else if (scan_end) begin
                        miss  <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        scan_idx <= scan_idx + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            // Load clears any claim on that entry
            if (exp_wr) begin
                tab_valid[exp_index]   <= 1'b1;
                tab_claimed[exp_index] <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Table contents and search key

    always_ff @(posedge axis_packet_in) begin
        if (exp_wr) begin
            tab_dest[exp_index] <= exp_dest;
            tab_blen[exp_index] <= exp_blen;
            tab_crc[exp_index]  <= exp_crc;
        end
        if (summary.valid && summary.ready) begin
            key_dest <= summary.dest;
            key_blen <= summary.blen;
            key_crc  <= summary.crc;
        end
    end

endmodule

`default_nettype wire

// File: src/pkt_reassembler.sv
// Per-destination CRC-32 and byte count, tkeep bytes taken low to high with holes skipped
// Lengths past MTU_BYTES wrap, so longer packets are not reported correctly
`timescale 1ns/10ps
`default_nettype none

module pkt_reassembler (
    input  logic        axis_packet_in,
    input  logic        rst_n,
    axis_word_if.dst    in,
    pkt_summary_if.src  summary
);
    import pkt_check_pkg::*;

    crc_t  crc_state [NUM_DESTS];
    blen_t len_state [NUM_DESTS];
    logic  beat;
    crc_t  next_crc;
    blen_t next_len;

    ////////////////////////////////////////
    // Functions

    // Bitwise reflected CRC over the enabled bytes of one beat
    function automatic crc_t crc_update(crc_t crc, data_t data, keep_t keep);
        crc_t c;
        c = crc;
        for (int b = 0; b < DATA_BYTES; b++) begin
            if (keep[b]) begin
                c = c ^ crc_t'(data[8*b +: 8]);
                for (int i = 0; i < 8; i++) begin
                    c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
                end
            end
        end
        return c;
    endfunction

    function automatic blen_t keep_bytes(keep_t keep);
        blen_t n;
        n = '0;
        for (int b = 0; b < DATA_BYTES; b++) begin
            n = n + blen_t'(keep[b]);
        end
        return n;
    endfunction

    ////////////////////////////////////////
    // Beat acceptance

    // Take a beat unless a summary is stuck waiting
    assign in.ready = !summary.valid || summary.ready;
    assign beat     = in.valid && in.ready;

    assign next_crc = crc_update(crc_state[in.dest], in.data, in.keep);
    assign next_len = len_state[in.dest] + keep_bytes(in.keep);

    ////////////////////////////////////////
    // Running state and summary valid

    always_ff @(posedge axis_packet_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int d = 0; d < NUM_DESTS; d++) begin
                crc_state[d] <= CRC_INIT;
                len_state[d] <= '0;
            end
            summary.valid <= 1'b0;
        end else begin
            if (summary.valid && summary.ready) begin
                summary.valid <= 1'b0;
            end
            if (beat) begin
                if (in.last) begin
                    // Packet done, start this destination afresh
                    crc_state[in.dest] <= CRC_INIT;
                    len_state[in.dest] <= '0;
                    summary.valid      <= 1'b1;
                end else begin
                    crc_state[in.dest] <= next_crc;
                    len_state[in.dest] <= next_len;
                end
            end
        end
    end

    // Summary fields, final CRC is inverted
    always_ff @(posedge axis_packet_in) begin
        if (beat && in.last) begin
            summary.dest <= in.dest;
            summary.blen <= next_len;
            summary.crc  <= ~next_crc;
        end
    end

endmodule

`default_nettype wire

// File: src/axis_rx_stage.sv
// Two-entry skid stage, tready is a register and does not follow out.ready in the same cycle
`timescale 1ns/10ps
`default_nettype none

module axis_rx_stage (
    input  logic                 axis_packet_in,
    input  logic                 rst_n,
    input  logic                 tvalid,
    output logic                 tready,
    input  pkt_check_pkg::data_t tdata,
    input  pkt_check_pkg::keep_t tkeep,
    input  logic                 tlast,
    input  pkt_check_pkg::dest_t tdest,
    axis_word_if.src             out
);
    import pkt_check_pkg::*;

    logic  skid_valid;
    logic  skid_valid_next;
    data_t skid_data;
    keep_t skid_keep;
    logic  skid_last;
    dest_t skid_dest;
    logic  accept;
    logic  pop;
    logic  load_main;

    assign accept = tvalid && tready;
    assign pop    = out.valid && out.ready;

    // Output register empties or is free this cycle
    assign load_main = pop || !out.valid;

    always_comb begin
        skid_valid_next = skid_valid;
        if (skid_valid && load_main) begin
            skid_valid_next = 1'b0;
        end else if (accept && !load_main) begin
            skid_valid_next = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Control

    always_ff @(posedge axis_packet_in or negedge rst_n) begin
        if (!rst_n) begin
            out.valid  <= 1'b0;
            skid_valid <= 1'b0;
            tready     <= 1'b0;
        end else begin
            if (load_main) begin
                out.valid <= skid_valid || accept;
            end
            skid_valid <= skid_valid_next;
            // Open only while the skid entry will be empty
            tready     <= !skid_valid_next;
        end
    end

    ////////////////////////////////////////
    // Payload

    always_ff @(posedge axis_packet_in) begin
        if (load_main) begin
            if (skid_valid) begin
                out.data <= skid_data;
                out.keep <= skid_keep;
                out.last <= skid_last;
                out.dest <= skid_dest;
            end else if (accept) begin
                out.data <= tdata;
                out.keep <= tkeep;
                out.last <= tlast;
                out.dest <= tdest;
            end
        end
        // Park the beat when downstream stalls
        if (accept && !load_main) begin
            skid_data <= tdata;
            skid_keep <= tkeep;
            skid_last <= tlast;
            skid_dest <= tdest;
        end
    end

endmodule

`default_nettype wire

// File: src/pkt_summary_if.sv
// Finished-packet summary from reassembler to matcher
// Valid holds with stable fields until ready takes the summary
`timescale 1ns/10ps
`default_nettype none

interface pkt_summary_if;
    import pkt_check_pkg::*;

    logic  valid;
    logic  ready;
    dest_t dest;
    blen_t blen;
    crc_t  crc;

    modport src (
        output valid, dest, blen, crc,
        input  ready
    );

    modport dst (
        input  valid, dest, blen, crc,
        output ready
    );

endinterface

`default_nettype wire

// File: src/axis_word_if.sv
// One stream beat with valid/ready between internal stages
// A beat moves on a clock edge where valid and ready are both high
`timescale 1ns/10ps
`default_nettype none

interface axis_word_if;
    import pkt_check_pkg::*;

    logic  valid;
    logic  ready;
    data_t data;
    keep_t keep;
    logic  last;
    dest_t dest;

    // Producer side
    modport src (
        output valid, data, keep, last, dest,
        input  ready
    );

    // Consumer side
    modport dst (
        input  valid, data, keep, last, dest,
        output ready
    );

endinterface

`default_nettype wire

// File: src/pkt_check_pkg.sv
// Widths and CRC constants shared by the packet checker
// Beat width is fixed at four bytes, and lengths are sized for packets up to MTU_BYTES
`default_nettype none

package pkt_check_pkg;

    ////////////////////////////////////////
    // Beat geometry

    localparam int DATA_BYTES = 4;
    localparam int MTU_BYTES  = 1500;

    typedef logic [DATA_BYTES*8-1:0] data_t;
    typedef logic [DATA_BYTES-1:0]   keep_t;
    typedef logic [1:0]              dest_t;

    // One reassembly context per destination
    localparam int NUM_DESTS = 2 ** $bits(dest_t);

    ////////////////////////////////////////
    // Packet summary fields

    typedef logic [$clog2(MTU_BYTES+1)-1:0] blen_t;
    typedef logic [31:0]                    crc_t;

    // Reflected CRC-32 with all-ones seed
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY = 32'hEDB8_8320;

endpackage

`default_nettype wire
